//--- vlog.f
common/exp_pkg.sv
logic/fixed_round.sv
exp/integer_lut_16.sv
exp/fractional_lut_16.sv
exp/series_approx.sv
exp/exp.sv
logic/neg_exp_unit.sv
dv/neg_exp_unit_properties.sv
dv/tb_neg_exp_unit.sv

//--- Makefile
# Verilator build and run for the negative-exponential unit

VERILATOR  ?= verilator
TOP        ?= tb_neg_exp_unit
RTL_TOP    ?= neg_exp_unit
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/1ps
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE) -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)
PASS_MSG   ?= TESTBENCH PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: build
	@output="$$(./$(SIM_BIN))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_neg_exp_unit.sv
`default_nettype none

module tb_neg_exp_unit;
  timeunit 1ns;
  timeprecision 1ps;

  import exp_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 16;
  localparam int DRIVE_DELAY     = 1;
  localparam int NUM_RANDOM      = 64;
  localparam int BURST_LEN       = 16;
  localparam int WATCHDOG_MARGIN = 40;
  localparam int RAND_BITS       = IN_FRAC + INT_IDX_WIDTH;  // keeps x below 16

  localparam logic [1:0] KIND_EXACT  = 2'd0;
  localparam logic [1:0] KIND_SERIES = 2'd1;
  localparam logic [1:0] KIND_SAT    = 2'd2;
  localparam logic [1:0] KIND_RANDOM = 2'd3;

  typedef struct packed {
    exp_arg_t    arg;
    logic        back_to_back;  // next entry follows without an idle cycle
    logic [31:0] expected;
    logic [1:0]  kind;
  } stim_t;

  typedef struct packed {
    exp_arg_t    arg;
    logic [31:0] expected;
    logic [1:0]  kind;
    logic [31:0] due;           // cycle in which the result must show
  } sb_item_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 in_valid;
  exp_arg_t             arg;
  logic                 out_valid;
  logic [OUT_WIDTH-1:0] result;

  stim_t       stim_table[$];
  sb_item_t    sb_queue[$];
  sb_item_t    mon_item;
  logic [31:0] cycle = '0;
  logic [31:0] lfsr_state;
  logic [31:0] last_series;
  logic [31:0] held_result;
  logic        held_valid = 1'b0;
  logic        table_loaded = 1'b0;
  int          value_errors = 0;
  int          protocol_errors = 0;

  neg_exp_unit u_neg_exp_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .arg       (arg),
    .out_valid (out_valid),
    .result    (result)
  );

  initial
  begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 32'd1;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  function automatic logic [31:0] ref_exp(input logic [31:0] raw);
    real x;
    real scaled;
    x = real'(raw) / 65536.0;
    scaled = $exp(-x) * 65536.0;
    return 32'($rtoi(scaled + 0.5));
  endfunction

  function automatic int tolerance_for(input logic [1:0] kind);
    case (kind)
      KIND_EXACT:  return 2;
      KIND_SAT:    return 0;
      default:     return 4;
    endcase
  endfunction

  task automatic take_random_arg(output exp_arg_t value);
    logic [RAND_BITS-1:0] bits;
    for (int i = 0; i < RAND_BITS; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      bits[i] = lfsr_state[0];  // one step per bit
    end
    value = '0;
    value.raw[RAND_BITS-1:0] = bits;
  endtask

  task automatic add_entry(
    input logic [31:0] raw,
    input logic        b2b,
    input logic [31:0] expected,
    input logic [1:0]  kind
  );
    stim_t entry;
    entry.arg.raw      = raw;
    entry.back_to_back = b2b;
    entry.expected     = expected;
    entry.kind         = kind;
    stim_table.push_back(entry);
  endtask

  // expected values are round(e^-x * 2^16)
  task automatic load_table();
    add_entry(32'h0000_0000, 1'b1, 32'd65536, KIND_EXACT);
    add_entry(32'h0001_0000, 1'b1, 32'd24109, KIND_EXACT);
    add_entry(32'h0002_0000, 1'b1, 32'd8869,  KIND_EXACT);
    add_entry(32'h0003_0000, 1'b0, 32'd3263,  KIND_EXACT);
    add_entry(32'h0004_0000, 1'b1, 32'd1200,  KIND_EXACT);
    add_entry(32'h0005_0000, 1'b1, 32'd442,   KIND_EXACT);
    add_entry(32'h0006_0000, 1'b1, 32'd162,   KIND_EXACT);
    add_entry(32'h0007_0000, 1'b1, 32'd60,    KIND_EXACT);
    add_entry(32'h0008_0000, 1'b1, 32'd22,    KIND_EXACT);
    add_entry(32'h0009_0000, 1'b1, 32'd8,     KIND_EXACT);
    add_entry(32'h000a_0000, 1'b1, 32'd3,     KIND_EXACT);
    add_entry(32'h000b_0000, 1'b1, 32'd1,     KIND_EXACT);
    add_entry(32'h000c_0000, 1'b1, 32'd0,     KIND_EXACT);
    add_entry(32'h000d_0000, 1'b1, 32'd0,     KIND_EXACT);
    add_entry(32'h000e_0000, 1'b1, 32'd0,     KIND_EXACT);
    add_entry(32'h000f_0000, 1'b0, 32'd0,     KIND_EXACT);
    add_entry(32'h0000_2000, 1'b1, 32'd57835, KIND_EXACT);  // k/8 steps
    add_entry(32'h0000_4000, 1'b1, 32'd51039, KIND_EXACT);
    add_entry(32'h0000_6000, 1'b1, 32'd45042, KIND_EXACT);
    add_entry(32'h0000_8000, 1'b1, 32'd39750, KIND_EXACT);
    add_entry(32'h0000_a000, 1'b1, 32'd35079, KIND_EXACT);
    add_entry(32'h0000_c000, 1'b1, 32'd30957, KIND_EXACT);
    add_entry(32'h0000_e000, 1'b0, 32'd27319, KIND_EXACT);
    add_entry(32'h0000_0001, 1'b1, 32'd65535, KIND_SERIES);  // rising order
    add_entry(32'h0000_0010, 1'b1, 32'd65520, KIND_SERIES);
    add_entry(32'h0000_0100, 1'b1, 32'd65280, KIND_SERIES);
    add_entry(32'h0000_0800, 1'b1, 32'd63520, KIND_SERIES);
    add_entry(32'h0000_1000, 1'b1, 32'd61565, KIND_SERIES);
    add_entry(32'h0000_1fff, 1'b0, 32'd57836, KIND_SERIES);
    add_entry(32'h0010_0000, 1'b1, 32'd0,     KIND_SAT);
    add_entry(32'h03e8_0000, 1'b1, 32'd0,     KIND_SAT);
    add_entry(32'hffff_ffff, 1'b0, 32'd0,     KIND_SAT);
  endtask

  task automatic send_arg(
    input exp_arg_t    value,
    input logic [31:0] expected,
    input logic [1:0]  kind
  );
    sb_item_t item;
    in_valid      = 1'b1;
    arg           = value;
    item.arg      = value;
    item.expected = expected;
    item.kind     = kind;
    item.due      = cycle + 32'd2;  // two-cycle latency
    sb_queue.push_back(item);
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic idle_cycle();
    in_valid = 1'b0;
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic check_result(input sb_item_t item, input logic [31:0] actual);
    int diff;
    int tol;
    diff = int'(actual) - int'(item.expected);
    if (diff < 0)
    begin
      diff = -diff;
    end
    tol = tolerance_for(item.kind);
    assert (diff <= tol)
    else
    begin
      $display("FAILED time=%0t arg=%h expected=%0d actual=%0d",
               $time, item.arg.raw, item.expected, actual);
      value_errors++;
    end
    assert (actual <= 32'd65536)
    else
    begin
      $display("FAILED time=%0t arg=%h result %0d is above one", $time, item.arg.raw, actual);
      value_errors++;
    end
    if (item.kind == KIND_SERIES)
    begin
      assert (actual <= last_series)
      else
      begin
        $display("FAILED time=%0t arg=%h series result %0d rose above %0d",
                 $time, item.arg.raw, actual, last_series);
        value_errors++;
      end
      last_series = actual;
    end
  endtask

  // outputs are read mid-cycle, away from the driving edge
  always @(negedge clk)
  begin
    if (sb_queue.size() != 0 && sb_queue[0].due == cycle)
    begin
      mon_item = sb_queue.pop_front();
      assert (out_valid === 1'b1)
      else
      begin
        $display("out_valid missing at time %0t for argument %h", $time, mon_item.arg.raw);
        protocol_errors++;
      end
      if (out_valid === 1'b1)
      begin
        check_result(mon_item, result);
        held_result = result;
        held_valid  = 1'b1;
      end
    end
    else
    begin
      assert (out_valid === 1'b0)
      else
      begin
        $display("out_valid was high at time %0t with no result due", $time);
        protocol_errors++;
      end
      if (held_valid)
      begin
        assert (result === held_result)
        else
        begin
          $display("result changed at time %0t while out_valid was low", $time);
          protocol_errors++;
        end
      end
    end
  end

  initial
  begin
    int watchdog_ns;
    wait (table_loaded);
    watchdog_ns = (stim_table.size() + NUM_RANDOM + WATCHDOG_MARGIN) * CLK_PERIOD;
    #(watchdog_ns);
    $display("watchdog expired at time %0t with %0d results outstanding",
             $time, sb_queue.size());
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    exp_arg_t rand_arg;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    arg         = '0;
    lfsr_state  = 32'h1eef;
    last_series = 32'hffff_ffff;
    load_table();
    table_loaded = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    idle_cycle();
    idle_cycle();

    foreach (stim_table[i])
    begin
      send_arg(stim_table[i].arg, stim_table[i].expected, stim_table[i].kind);
      if (!stim_table[i].back_to_back)
      begin
        idle_cycle();
      end
    end

    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      take_random_arg(rand_arg);
      send_arg(rand_arg, ref_exp(rand_arg.raw), KIND_RANDOM);
      if (i % BURST_LEN == BURST_LEN - 1)
      begin
        idle_cycle();  // gap between bursts
      end
    end
    idle_cycle();

    while (sb_queue.size() != 0)
    begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);  // quiet tail after the last result

    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/neg_exp_unit_properties.sv
`default_nettype none

module neg_exp_unit_properties (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          in_valid,
  input logic                          out_valid,
  input logic [exp_pkg::OUT_WIDTH-1:0] result
);
  timeunit 1ns;
  timeprecision 1ps;

  import exp_pkg::*;

  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else $error("out_valid high after a reset cycle");

  // strobe comes out exactly two cycles after it went in
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> ##2 out_valid)
    else $error("out_valid missing two cycles after in_valid");

  a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(in_valid, 2))
    else $error("out_valid without in_valid two cycles earlier");

  a_range: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (result <= (OUT_WIDTH'(1) << OUT_FRAC)))
    else $error("result above one");

endmodule

bind neg_exp_unit neg_exp_unit_properties u_neg_exp_unit_properties (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .result    (result)
);

`default_nettype wire

//--- logic/neg_exp_unit.sv
`default_nettype none

// e^-x with a two-cycle fixed latency, one argument accepted per cycle
module neg_exp_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  input  exp_pkg::exp_arg_t             arg,
  output logic                          out_valid,
  output logic [exp_pkg::OUT_WIDTH-1:0] result
);
  import exp_pkg::*;

  exp_stage_t           in_stage;    // registered argument and strobe
  logic [OUT_WIDTH-1:0] exp_result;  // combinational result of the stage

  // input register, the argument only loads with a strobe
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      in_stage.valid <= 1'b0;
    end
    else
    begin
      in_stage.valid <= in_valid;
      if (in_valid)
      begin
        in_stage.arg <= arg;
      end
    end
  end

  exp u_exp (
    .arg    (in_stage.arg),
    .result (exp_result)
  );

  // output register, result holds while no strobe arrives
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= in_stage.valid;
      if (in_stage.valid)
      begin
        result <= exp_result;
      end
    end
  end

endmodule

`default_nettype wire

//--- exp/exp.sv
`default_nettype none

module exp (
  input  exp_pkg::exp_arg_t              arg,
  output logic [exp_pkg::OUT_WIDTH-1:0]  result
);
  import exp_pkg::*;

  exp_arg_t                split;          // argument after saturation
  logic [LUT_WIDTH-1:0]    int_factor;     // e^-int_part
  logic [LUT_WIDTH-1:0]    frac_factor;    // e^-(frac_hi/8)
  logic [APPROX_WIDTH-2:0] series_out;     // e^-frac_lo in Q0.16
  logic [APPROX_WIDTH-1:0] series_factor;  // widened to Q1.16
  logic [PDT_WIDTH-1:0]    product;        // Q3.48

  // anything at or above 16 is pushed to the largest in-range argument,
  // whose integer factor is already zero
  always_comb
  begin
    split = arg;
    if (|arg.fields.sat)
    begin
      split.fields.int_part = '1;
      split.fields.frac_hi  = '1;
      split.fields.frac_lo  = '1;
    end
  end

  integer_lut_16 u_integer_lut_16 (
    .address  (split.fields.int_part),
    .data_out (int_factor)
  );

  fractional_lut_16 u_fractional_lut_16 (
    .address  (split.fields.frac_hi),
    .data_out (frac_factor)
  );

  series_approx u_series_approx (
    .data_in  (split.fields.frac_lo),
    .data_out (series_out)
  );

  assign series_factor = {1'b0, series_out};  // top bit is never set

  // three-way product, evaluated at the full product width
  assign product = int_factor * frac_factor * series_factor;

  fixed_round #(
    .IN_WIDTH       (PDT_WIDTH),
    .IN_FRAC_WIDTH  (3 * LUT_FRAC),
    .OUT_WIDTH      (OUT_WIDTH),
    .OUT_FRAC_WIDTH (OUT_FRAC)
  ) u_fixed_round (
    .data_in  (product),
    .data_out (result)
  );

endmodule

`default_nettype wire

//--- exp/series_approx.sv
`default_nettype none

// e^-f ~ 1 - f + f^2/2 - f^3/6 for f below 1/8, f given in units of 2^-16
module series_approx (
  input  logic [exp_pkg::REM_WIDTH-1:0]      data_in,
  output logic [exp_pkg::APPROX_WIDTH-2:0]   data_out
);
  import exp_pkg::*;

  logic [2*REM_WIDTH-1:0]            f_sq;         // f^2 in units of 2^-32
  logic [2*REM_WIDTH-LUT_FRAC-1:0]   f_sq_q;       // f^2 back in units of 2^-16
  logic [3*REM_WIDTH-LUT_FRAC-1:0]   f_cube;       // f^3 in units of 2^-32
  logic [3*REM_WIDTH-2*LUT_FRAC-1:0] f_cube_q;     // f^3 in units of 2^-16
  logic [3*REM_WIDTH-LUT_FRAC-1:0]   sixth_pdt;    // f^3 times one sixth
  logic [2*REM_WIDTH-LUT_FRAC-2:0]   second_term;  // f^2/2
  logic [3*REM_WIDTH-2*LUT_FRAC-1:0] third_term;   // f^3/6
  logic [LUT_WIDTH-1:0]              sum;          // Q1.16

  assign f_sq   = data_in * data_in;
  assign f_sq_q = f_sq[2*REM_WIDTH-1:LUT_FRAC];  // truncating

  assign f_cube   = f_sq_q * data_in;
  assign f_cube_q = f_cube[3*REM_WIDTH-LUT_FRAC-1:LUT_FRAC];

  // 10923 is round(2^16 / 6)
  assign sixth_pdt  = f_cube_q * 16'd10923;
  assign third_term = sixth_pdt[3*REM_WIDTH-LUT_FRAC-1:LUT_FRAC];

  // divide by two is one more bit dropped
  assign second_term = f_sq[2*REM_WIDTH-1:LUT_FRAC+1];

  // intermediate wrap is harmless, the final sum lies in [0.88, 1.0]
  assign sum = {1'b1, {LUT_FRAC{1'b0}}} - data_in + second_term - third_term;

  // only f = 0 reaches 1.0, which does not fit Q0.16
  assign data_out = sum[LUT_FRAC] ? '1 : sum[LUT_FRAC-1:0];

endmodule

`default_nettype wire

//--- exp/fractional_lut_16.sv
`default_nettype none

module fractional_lut_16 (
  input  logic [exp_pkg::FRAC_IDX_WIDTH-1:0] address,
  output logic [exp_pkg::LUT_WIDTH-1:0]      data_out
);
  import exp_pkg::*;

  // round(e^-(k/8) * 2^16)
  always_comb
  begin
    case (address)
      3'd0: data_out = 17'd65536;
      3'd1: data_out = 17'd57835;
      3'd2: data_out = 17'd51039;
      3'd3: data_out = 17'd45042;
      3'd4: data_out = 17'd39750;
      3'd5: data_out = 17'd35079;
      3'd6: data_out = 17'd30957;
      3'd7: data_out = 17'd27319;
      default: data_out = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- exp/integer_lut_16.sv
`default_nettype none

// e^-n for the integer part of the argument, entries are round(e^-n * 2^16)
module integer_lut_16 (
  input  logic [exp_pkg::INT_IDX_WIDTH-1:0] address,
  output logic [exp_pkg::LUT_WIDTH-1:0]     data_out
);
  import exp_pkg::*;

  always_comb
  begin
    case (address)
      4'd0:  data_out = 17'd65536;  // needs the 17th bit
      4'd1:  data_out = 17'd24109;
      4'd2:  data_out = 17'd8869;
      4'd3:  data_out = 17'd3263;
      4'd4:  data_out = 17'd1200;
      4'd5:  data_out = 17'd442;
      4'd6:  data_out = 17'd162;
      4'd7:  data_out = 17'd60;
      4'd8:  data_out = 17'd22;
      4'd9:  data_out = 17'd8;
      4'd10: data_out = 17'd3;
      4'd11: data_out = 17'd1;
      4'd12: data_out = 17'd0;      // below half an lsb from here on
      4'd13: data_out = 17'd0;
      4'd14: data_out = 17'd0;
      4'd15: data_out = 17'd0;
      default: data_out = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/fixed_round.sv
`default_nettype none

// narrows a fixed-point word with round-half-up, saturating on overflow
module fixed_round #(
  parameter int IN_WIDTH       = 51,
  parameter int IN_FRAC_WIDTH  = 48,
  parameter int OUT_WIDTH      = 32,
  parameter int OUT_FRAC_WIDTH = 16
) (
  input  logic [IN_WIDTH-1:0]  data_in,
  output logic [OUT_WIDTH-1:0] data_out
);

  localparam int SHIFT     = IN_FRAC_WIDTH - OUT_FRAC_WIDTH;  // fraction bits dropped
  localparam int RND_WIDTH = IN_WIDTH - SHIFT + 1;            // one spare bit for the carry
  localparam int WIDE      = (RND_WIDTH > OUT_WIDTH) ? RND_WIDTH : OUT_WIDTH;
  localparam logic [WIDE-1:0] OUT_MAX = WIDE'({OUT_WIDTH{1'b1}});

  logic [RND_WIDTH-1:0] rounded;
  logic [WIDE-1:0]      wide;

  // the first dropped bit decides the rounding
  assign rounded = {1'b0, data_in[IN_WIDTH-1:SHIFT]} + RND_WIDTH'(data_in[SHIFT-1]);

  assign wide = WIDE'(rounded);

  assign data_out = (wide > OUT_MAX) ? '1 : wide[OUT_WIDTH-1:0];

endmodule

`default_nettype wire

//--- common/exp_pkg.sv
`default_nettype none

package exp_pkg;

  // input argument, unsigned Q16.16 magnitude
  localparam int IN_WIDTH = 32;
  localparam int IN_FRAC = 16;

  // output result, Q16.16
  localparam int OUT_WIDTH = 32;
  localparam int OUT_FRAC = 16;

  // table entries in Q1.16, the extra integer bit holds e^0
  localparam int LUT_WIDTH = 17;
  localparam int LUT_FRAC = 16;

  // series factor, Q1.16 with the top bit always zero
  localparam int APPROX_WIDTH = 17;

  // product of three Q1.16 factors gives Q3.48
  localparam int PDT_WIDTH = 51;

  // table address widths
  localparam int INT_IDX_WIDTH = 4;   // e^-n for n 0..15
  localparam int FRAC_IDX_WIDTH = 3;  // e^-(k/8) for k 0..7

  // low fraction bits handled by the series
  localparam int REM_WIDTH = 13;

  // integer bits above the integer table range, nonzero means x >= 16
  localparam int SAT_WIDTH = IN_WIDTH - IN_FRAC - INT_IDX_WIDTH;

  // argument word split into the parts the datapath works on
  typedef struct packed {
    logic [SAT_WIDTH-1:0]      sat;       // bits 31..20
    logic [INT_IDX_WIDTH-1:0]  int_part;  // bits 19..16
    logic [FRAC_IDX_WIDTH-1:0] frac_hi;   // bits 15..13
    logic [REM_WIDTH-1:0]      frac_lo;   // bits 12..0
  } exp_fields_t;

  // same 32-bit word, read as a number or as split fields
  typedef union packed {
    logic [IN_WIDTH-1:0] raw;
    exp_fields_t         fields;
  } exp_arg_t;

  // contents of the input register of the top
  typedef struct packed {
    logic     valid;
    exp_arg_t arg;
  } exp_stage_t;

endpackage

`default_nettype wire
